// ==== verilog.f ====
+incdir+test
rtl/island_pkg.sv
rtl/bus_req_if.sv
rtl/addr_decoder.sv
rtl/target_arbiter.sv
rtl/island_xbar.sv
test/tb_island_xbar.sv

// ==== Bender.yml ====
package:
  name: island_xbar

sources:
  - rtl/island_pkg.sv
  - rtl/bus_req_if.sv
  - rtl/addr_decoder.sv
  - rtl/target_arbiter.sv
  - rtl/island_xbar.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_island_xbar.sv

// ==== test/tb_island_tasks.svh ====
////////////////////////////////////////////////////////////////////////////
// Testbench helpers with LFSR, address rules, compare and driver tasks,
// expected-request queues and the directed tests
////////////////////////////////////////////////////////////////////////////

island_pkg::req_payload_t q_tlul_host [$];
island_pkg::req_payload_t q_tlul_cls  [$];
island_pkg::req_payload_t q_idma_host [$];
island_pkg::req_payload_t q_idma_cls  [$];

// Galois LFSR stepped once per bit
function automatic logic [31:0] take_bits(input int unsigned n);
   logic [31:0] val;
   val = '0;
   for (int unsigned i = 0; i < n; i++) begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
      val    = {val[30:0], lfsr_q[0]};
   end
   return val;
endfunction

// 0 host, 1 cluster, 2 decode miss
function automatic int expected_target(input island_pkg::addr_t addr);
   if (addr >= island_pkg::HostBase && addr < island_pkg::HostEnd) begin
      return 0;
   end
   if (addr >= island_pkg::ClsBase && addr < island_pkg::ClsEnd) begin
      return 1;
   end
   return 2;
endfunction

// Host, cluster, gap, outside both rules
function automatic island_pkg::addr_t random_addr();
   logic [1:0]  region;
   logic [31:0] r;
   region = 2'(take_bits(2));
   r      = take_bits(32);
   case (region)
      2'd0: return island_pkg::HostBase + r % (island_pkg::HostEnd - island_pkg::HostBase);
      2'd1: return island_pkg::ClsBase + r % (island_pkg::ClsEnd - island_pkg::ClsBase);
      2'd2: return island_pkg::HostEnd + r % (island_pkg::ClsBase - island_pkg::HostEnd);
      default: return r[31] ? r % island_pkg::HostBase : island_pkg::ClsEnd + r % 32'h5000_0000;
   endcase
endfunction

function automatic island_pkg::req_payload_t make_req(input int ini,
                                                      input island_pkg::addr_t addr,
                                                      input logic write);
   island_pkg::req_payload_t p;
   p.addr  = addr;
   p.data  = take_bits(island_pkg::DataWidth);
   p.write = write;
   p.src   = island_pkg::src_t'(ini);
   return p;
endfunction

function automatic island_pkg::req_payload_t target_payload(input int tgt);
   if (tgt == 0) begin
      return '{addr: host_req_addr_o, data: host_req_data_o,
               write: host_req_write_o, src: host_req_src_o};
   end
   return '{addr: cls_req_addr_o, data: cls_req_data_o,
            write: cls_req_write_o, src: cls_req_src_o};
endfunction

function automatic logic ini_ready(input int ini);
   return (ini == 0) ? tlul_req_ready_o : idma_req_ready_o;
endfunction

task automatic check_bit(input string name, input logic exp, input logic act);
   if (act !== exp) begin
      mismatches++;
      $display("MISMATCH %s: expected %b, actual %b", name, exp, act);
   end
endtask

task automatic check_payload(input string name, input island_pkg::req_payload_t exp,
                             input island_pkg::req_payload_t act);
   if (act !== exp) begin
      mismatches++;
      $display("MISMATCH %s: addr/data/write/src expected %h/%h/%b/%0d, actual %h/%h/%b/%0d",
               name, exp.addr, exp.data, exp.write, exp.src,
               act.addr, act.data, act.write, act.src);
   end
endtask

task automatic drive_req(input int ini, input logic valid, input island_pkg::req_payload_t p);
   if (ini == 0) begin
      tlul_req_valid_i = valid;
      tlul_req_addr_i  = p.addr;
      tlul_req_data_i  = p.data;
      tlul_req_write_i = p.write;
   end else begin
      idma_req_valid_i = valid;
      idma_req_addr_i  = p.addr;
      idma_req_data_i  = p.data;
      idma_req_write_i = p.write;
   end
endtask

task automatic idle_inputs();
   drive_req(0, 1'b0, '0);
   drive_req(1, 1'b0, '0);
   host_req_ready_i = 1'b1;
   cls_req_ready_i  = 1'b1;
endtask

task automatic apply_reset();
   idle_inputs();
   rst_n_i = 1'b0;
   repeat (8) @(negedge clk_i);
   rst_n_i = 1'b1;
endtask

// Returns on the falling edge after the accepting rising edge
task automatic send_req(input string name, input int ini, input island_pkg::req_payload_t p);
   int unsigned waited;
   waited = 0;
   drive_req(ini, 1'b1, p);
   #1;
   while (!ini_ready(ini) && waited < 100) begin
      @(negedge clk_i);
      #1;
      waited++;
   end
   if (!ini_ready(ini)) begin
      failures++;
      $display("ERROR %s: request was not accepted within 100 cycles", name);
   end
   @(negedge clk_i);
   drive_req(ini, 1'b0, p);
endtask

task automatic push_expected(input int ini, input int tgt, input island_pkg::req_payload_t p);
   case (ini * 2 + tgt)
      0: q_tlul_host.push_back(p);
      1: q_tlul_cls.push_back(p);
      2: q_idma_host.push_back(p);
      default: q_idma_cls.push_back(p);
   endcase
endtask

// Source index picks the queue
task automatic pop_check(input int tgt, input island_pkg::req_payload_t act);
   island_pkg::req_payload_t exp;
   int unsigned              depth;
   case (int'(act.src) * 2 + tgt)
      0: depth = q_tlul_host.size();
      1: depth = q_tlul_cls.size();
      2: depth = q_idma_host.size();
      default: depth = q_idma_cls.size();
   endcase
   if (depth == 0) begin
      failures++;
      $display("ERROR random: target %0d delivered a request from initiator %0d never sent",
               tgt, act.src);
      return;
   end
   case (int'(act.src) * 2 + tgt)
      0: exp = q_tlul_host.pop_front();
      1: exp = q_tlul_cls.pop_front();
      2: exp = q_idma_host.pop_front();
      default: exp = q_idma_cls.pop_front();
   endcase
   check_payload("random traffic", exp, act);
endtask

////////////////////////////////////////////////////////////////////////////
// Directed tests
////////////////////////////////////////////////////////////////////////////

task automatic test_reset();
   check_bit("reset host valid", 1'b0, host_req_valid_o);
   check_bit("reset cluster valid", 1'b0, cls_req_valid_o);
   check_bit("reset tlul decerr", 1'b0, tlul_decerr_o);
   check_bit("reset idma decerr", 1'b0, idma_decerr_o);
endtask

task automatic test_route(input string name, input int ini, input int tgt,
                          input island_pkg::addr_t addr, input logic write);
   island_pkg::req_payload_t p;
   p = make_req(ini, addr, write);
   send_req(name, ini, p);
   check_bit({name, " valid"}, 1'b1, (tgt == 0) ? host_req_valid_o : cls_req_valid_o);
   check_payload(name, p, target_payload(tgt));
   check_bit({name, " other idle"}, 1'b0, (tgt == 0) ? cls_req_valid_o : host_req_valid_o);
   @(negedge clk_i);
   check_bit({name, " drained"}, 1'b0, (tgt == 0) ? host_req_valid_o : cls_req_valid_o);
endtask

task automatic test_decode_errors();
   island_pkg::addr_t bad [3];
   int                ini;
   bad = '{island_pkg::HostBase - 1, island_pkg::HostEnd, island_pkg::ClsEnd};
   foreach (bad[i]) begin
      ini = i % 2;
      drive_req(ini, 1'b1, make_req(ini, bad[i], 1'b0));
      #1;
      check_bit("decode error ready", 1'b1, ini_ready(ini));
      @(negedge clk_i);
      drive_req(ini, 1'b0, '0);
      check_bit("decode error pulse", 1'b1, (ini == 0) ? tlul_decerr_o : idma_decerr_o);
      check_bit("decode error host idle", 1'b0, host_req_valid_o);
      check_bit("decode error cluster idle", 1'b0, cls_req_valid_o);
      @(negedge clk_i);
      check_bit("decode error pulse end", 1'b0, (ini == 0) ? tlul_decerr_o : idma_decerr_o);
   end
endtask

task automatic test_contention();
   island_pkg::req_payload_t p_tlul;
   island_pkg::req_payload_t p_tlul2;
   island_pkg::req_payload_t p_idma;
   p_tlul  = make_req(0, island_pkg::HostBase + 32'h100, 1'b1);
   p_tlul2 = make_req(0, island_pkg::HostBase + 32'h200, 1'b0);
   p_idma  = make_req(1, island_pkg::HostBase + 32'h300, 1'b1);
   host_req_ready_i = 1'b0;
   drive_req(0, 1'b1, p_tlul);
   drive_req(1, 1'b1, p_idma);
   #1;
   check_bit("contention tlul ready", 1'b1, tlul_req_ready_o);
   check_bit("contention idma ready", 1'b0, idma_req_ready_o);
   @(negedge clk_i);
   drive_req(0, 1'b1, p_tlul2);
   repeat (4) begin
      #1;
      check_bit("stall host valid", 1'b1, host_req_valid_o);
      check_payload("stall host payload", p_tlul, target_payload(0));
      check_bit("stall tlul ready", 1'b0, tlul_req_ready_o);
      check_bit("stall idma ready", 1'b0, idma_req_ready_o);
      @(negedge clk_i);
   end
   host_req_ready_i = 1'b1;
   #1;
   check_bit("release idma ready", 1'b1, idma_req_ready_o);
   check_bit("release tlul ready", 1'b0, tlul_req_ready_o);
   @(negedge clk_i);
   drive_req(1, 1'b0, p_idma);
   check_payload("release idma output", p_idma, target_payload(0));
   #1;
   check_bit("release tlul second ready", 1'b1, tlul_req_ready_o);
   @(negedge clk_i);
   drive_req(0, 1'b0, p_tlul2);
   check_payload("release tlul output", p_tlul2, target_payload(0));
   @(negedge clk_i);
   check_bit("release host drained", 1'b0, host_req_valid_o);
endtask

// Last 20 cycles drain with both target readies high
task automatic test_random(input int unsigned num_cycles);
   island_pkg::req_payload_t pend [2];
   logic                     busy [2];
   logic                     exp_err [2];
   island_pkg::addr_t        addr;
   logic                     wr;
   int                       tgt;
   pend    = '{'0, '0};
   busy    = '{1'b0, 1'b0};
   exp_err = '{1'b0, 1'b0};
   for (int unsigned c = 0; c < num_cycles + 20; c++) begin
      @(negedge clk_i);
      check_bit("random tlul decerr", exp_err[0], tlul_decerr_o);
      check_bit("random idma decerr", exp_err[1], idma_decerr_o);
      for (int i = 0; i < 2; i++) begin
         if (!busy[i] && c < num_cycles && take_bits(1) != 0) begin
            addr    = random_addr();
            wr      = (take_bits(1) != 0);
            pend[i] = make_req(i, addr, wr);
            busy[i] = 1'b1;
         end
         drive_req(i, busy[i], pend[i]);
      end
      host_req_ready_i = (c >= num_cycles) || (take_bits(1) != 0);
      cls_req_ready_i  = (c >= num_cycles) || (take_bits(1) != 0);
      #1;
      for (int i = 0; i < 2; i++) begin
         exp_err[i] = 1'b0;
         if (busy[i] && ini_ready(i)) begin
            tgt        = expected_target(pend[i].addr);
            exp_err[i] = (tgt == 2);
            if (tgt != 2) begin
               push_expected(i, tgt, pend[i]);
            end
            busy[i] = 1'b0;
         end
      end
      if (host_req_valid_o && host_req_ready_i) begin
         pop_check(0, target_payload(0));
      end
      if (cls_req_valid_o && cls_req_ready_i) begin
         pop_check(1, target_payload(1));
      end
   end
   if (q_tlul_host.size() + q_tlul_cls.size() + q_idma_host.size() + q_idma_cls.size() != 0) begin
      failures++;
      $display("ERROR random: accepted requests were never delivered to their target");
   end
endtask

// ==== test/tb_island_xbar.sv ====
////////////////////////////////////////////////////////////////////////////
// Crossbar testbench with clock, reset, DUT instance, LFSR state,
// watchdog, test sequence and closing report
////////////////////////////////////////////////////////////////////////////

module tb_island_xbar;

   localparam int unsigned MaxCycles  = 3000;
   localparam int unsigned RandCycles = 300;

   logic              clk_i = 1'b0;
   logic              rst_n_i;
   logic              tlul_req_valid_i;
   island_pkg::addr_t tlul_req_addr_i;
   island_pkg::data_t tlul_req_data_i;
   logic              tlul_req_write_i;
   logic              tlul_req_ready_o;
   logic              tlul_decerr_o;
   logic              idma_req_valid_i;
   island_pkg::addr_t idma_req_addr_i;
   island_pkg::data_t idma_req_data_i;
   logic              idma_req_write_i;
   logic              idma_req_ready_o;
   logic              idma_decerr_o;
   logic              host_req_valid_o;
   island_pkg::addr_t host_req_addr_o;
   island_pkg::data_t host_req_data_o;
   logic              host_req_write_o;
   island_pkg::src_t  host_req_src_o;
   logic              host_req_ready_i;
   logic              cls_req_valid_o;
   island_pkg::addr_t cls_req_addr_o;
   island_pkg::data_t cls_req_data_o;
   logic              cls_req_write_o;
   island_pkg::src_t  cls_req_src_o;
   logic              cls_req_ready_i;

   int unsigned cycles     = 0;
   int unsigned mismatches = 0;
   int unsigned failures   = 0;
   logic [31:0] lfsr_q     = 32'hf8db1465;

   island_xbar uut (.*);

   initial begin
      forever #10 clk_i = ~clk_i;
   end

   // Watchdog
   always @(posedge clk_i) begin
      cycles <= cycles + 1;
      if (cycles >= MaxCycles) begin
         $display("ERROR: run stopped after %0d cycles without finishing", cycles);
         $display("Errors: %0d mismatches, %0d other failures", mismatches, failures + 1);
         $display("Test failures found");
         $finish;
      end
   end

   `include "tb_island_tasks.svh"

   initial begin
      rst_n_i = 1'b0;
      idle_inputs();
      apply_reset();
      test_reset();
      test_route("host route", 0, 0, island_pkg::HostBase + 32'h1230, 1'b1);
      test_route("cluster route", 1, 1, island_pkg::ClsBase + 32'h40, 1'b0);
      test_decode_errors();
      // Priority back at tlul
      apply_reset();
      test_contention();
      test_random(RandCycles);
      $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
      if (mismatches == 0 && failures == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

// ==== rtl/island_xbar.sv ====
////////////////////////////////////////////////////////////////////////////
// Two-by-two request crossbar: tlul and idma initiators to host and
// cluster targets, address decoders and per-target arbiters
////////////////////////////////////////////////////////////////////////////

module island_xbar (
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   // tlul initiator
   input  logic                   tlul_req_valid_i,
   input  island_pkg::addr_t      tlul_req_addr_i,
   input  island_pkg::data_t      tlul_req_data_i,
   input  logic                   tlul_req_write_i,
   output logic                   tlul_req_ready_o,
   output logic                   tlul_decerr_o,
   // idma initiator
   input  logic                   idma_req_valid_i,
   input  island_pkg::addr_t      idma_req_addr_i,
   input  island_pkg::data_t      idma_req_data_i,
   input  logic                   idma_req_write_i,
   output logic                   idma_req_ready_o,
   output logic                   idma_decerr_o,
   // host target
   output logic                   host_req_valid_o,
   output island_pkg::addr_t      host_req_addr_o,
   output island_pkg::data_t      host_req_data_o,
   output logic                   host_req_write_o,
   output island_pkg::src_t       host_req_src_o,
   input  logic                   host_req_ready_i,
   // cluster target
   output logic                   cls_req_valid_o,
   output island_pkg::addr_t      cls_req_addr_o,
   output island_pkg::data_t      cls_req_data_o,
   output logic                   cls_req_write_o,
   output island_pkg::src_t       cls_req_src_o,
   input  logic                   cls_req_ready_i
);

   import island_pkg::*;

   localparam int unsigned IniTlul = 0;
   localparam int unsigned IniIdma = 1;

   logic [NumTargets-1:0]    tlul_tgt_req;
   logic [NumTargets-1:0]    idma_tgt_req;
   logic [NumTargets-1:0]    tlul_gnt;
   logic [NumTargets-1:0]    idma_gnt;
   logic [NumInitiators-1:0] host_req;
   logic [NumInitiators-1:0] cls_req;
   logic [NumInitiators-1:0] host_gnt;
   logic [NumInitiators-1:0] cls_gnt;
   req_payload_t [NumInitiators-1:0] ini_payload;

   bus_req_if tlul_if ();
   bus_req_if idma_if ();
   bus_req_if host_if ();
   bus_req_if cls_if ();

   ////////////////////////////////////////////////////////////////////////////
   // Initiator side
   ////////////////////////////////////////////////////////////////////////////

   assign tlul_if.valid   = tlul_req_valid_i;
   assign tlul_if.payload = '{addr: tlul_req_addr_i, data: tlul_req_data_i,
                              write: tlul_req_write_i, src: src_t'(IniTlul)};
   assign tlul_req_ready_o = tlul_if.ready;

   assign idma_if.valid   = idma_req_valid_i;
   assign idma_if.payload = '{addr: idma_req_addr_i, data: idma_req_data_i,
                              write: idma_req_write_i, src: src_t'(IniIdma)};
   assign idma_req_ready_o = idma_if.ready;

   addr_decoder i_tlul_dec (
      .clk_i     ( clk_i         ),
      .rst_n_i   ( rst_n_i       ),
      .ini       ( tlul_if       ),
      .gnt_i     ( tlul_gnt      ),
      .tgt_req_o ( tlul_tgt_req  ),
      .decerr_o  ( tlul_decerr_o )
   );

   addr_decoder i_idma_dec (
      .clk_i     ( clk_i         ),
      .rst_n_i   ( rst_n_i       ),
      .ini       ( idma_if       ),
      .gnt_i     ( idma_gnt      ),
      .tgt_req_o ( idma_tgt_req  ),
      .decerr_o  ( idma_decerr_o )
   );

   // Transpose requests and grants between initiator and target views
   always_comb begin
      ini_payload[IniTlul]  = tlul_if.payload;
      ini_payload[IniIdma]  = idma_if.payload;
      host_req[IniTlul]     = tlul_tgt_req[TgtHost];
      host_req[IniIdma]     = idma_tgt_req[TgtHost];
      cls_req[IniTlul]      = tlul_tgt_req[TgtCluster];
      cls_req[IniIdma]      = idma_tgt_req[TgtCluster];
      tlul_gnt[TgtHost]     = host_gnt[IniTlul];
      tlul_gnt[TgtCluster]  = cls_gnt[IniTlul];
      idma_gnt[TgtHost]     = host_gnt[IniIdma];
      idma_gnt[TgtCluster]  = cls_gnt[IniIdma];
   end

   ////////////////////////////////////////////////////////////////////////////
   // Target side
   ////////////////////////////////////////////////////////////////////////////

   target_arbiter #(
      .NumIni ( NumInitiators )
   ) i_host_arb (
      .clk_i         ( clk_i       ),
      .rst_n_i       ( rst_n_i     ),
      .req_i         ( host_req    ),
      .ini_payload_i ( ini_payload ),
      .gnt_o         ( host_gnt    ),
      .tgt           ( host_if     )
   );

   target_arbiter #(
      .NumIni ( NumInitiators )
   ) i_cls_arb (
      .clk_i         ( clk_i       ),
      .rst_n_i       ( rst_n_i     ),
      .req_i         ( cls_req     ),
      .ini_payload_i ( ini_payload ),
      .gnt_o         ( cls_gnt     ),
      .tgt           ( cls_if      )
   );

   assign host_req_valid_o = host_if.valid;
   assign host_req_addr_o  = host_if.payload.addr;
   assign host_req_data_o  = host_if.payload.data;
   assign host_req_write_o = host_if.payload.write;
   assign host_req_src_o   = host_if.payload.src;
   assign host_if.ready    = host_req_ready_i;

   assign cls_req_valid_o  = cls_if.valid;
   assign cls_req_addr_o   = cls_if.payload.addr;
   assign cls_req_data_o   = cls_if.payload.data;
   assign cls_req_write_o  = cls_if.payload.write;
   assign cls_req_src_o    = cls_if.payload.src;
   assign cls_if.ready     = cls_req_ready_i;

endmodule

// ==== rtl/target_arbiter.sv ====
////////////////////////////////////////////////////////////////////////////
// Per-target round-robin arbiter with a one-entry output register
////////////////////////////////////////////////////////////////////////////

module target_arbiter #(
   parameter int unsigned NumIni = 2
) (
   input  logic                                   clk_i,
   input  logic                                   rst_n_i,
   input  logic [NumIni-1:0]                      req_i,
   input  island_pkg::req_payload_t [NumIni-1:0]  ini_payload_i,
   output logic [NumIni-1:0]                      gnt_o,
   bus_req_if.initiator                           tgt
);

   import island_pkg::*;

   localparam int unsigned IdxWidth = (NumIni > 1) ? $clog2(NumIni) : 1;

   logic [IdxWidth-1:0] prio_q;
   logic [IdxWidth-1:0] sel;
   logic                found;
   logic                can_load;
   logic                valid_q;
   req_payload_t        payload_q;

   // Slot is free or drains this cycle
   assign can_load = ~valid_q | tgt.ready;

   // Scan requesters starting at the priority pointer
   always_comb begin
      int unsigned idx;
      sel   = prio_q;
      found = 1'b0;
      for (int unsigned i = 0; i < NumIni; i++) begin
         idx = (int'(prio_q) + i) % NumIni;
         if (!found && req_i[idx]) begin
            found = 1'b1;
            sel   = IdxWidth'(idx);
         end
      end
   end

   always_comb begin
      gnt_o = '0;
      if (can_load && found) begin
         gnt_o[sel] = 1'b1;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Output register
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         prio_q  <= '0;
         valid_q <= 1'b0;
      end else begin
         if (|gnt_o) begin
            valid_q <= 1'b1;
            // Winner drops to lowest priority
            if (sel == IdxWidth'(NumIni - 1)) begin
               prio_q <= '0;
            end else begin
               prio_q <= sel + 1'b1;
            end
         end else if (tgt.ready) begin
            valid_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (|gnt_o) begin
         payload_q     <= ini_payload_i[sel];
         payload_q.src <= src_t'(sel);
      end
   end

   assign tgt.valid   = valid_q;
   assign tgt.payload = payload_q;

   ////////////////////////////////////////////////////////////////////////////
   // Assertions
   ////////////////////////////////////////////////////////////////////////////

   a_payload_stable : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      (tgt.valid && !tgt.ready) |=> (tgt.valid && $stable(tgt.payload))
   ) else $error("target_arbiter: payload changed while stalled");

   a_gnt_onehot : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      $onehot0(gnt_o)
   ) else $error("target_arbiter: more than one grant");

endmodule

// ==== rtl/addr_decoder.sv ====
////////////////////////////////////////////////////////////////////////////
// Per-initiator address decode: target steering, ready return and
// decode-error pulse for addresses outside both rules
////////////////////////////////////////////////////////////////////////////

module addr_decoder (
   input  logic                              clk_i,
   input  logic                              rst_n_i,
   bus_req_if.target                         ini,
   input  logic [island_pkg::NumTargets-1:0] gnt_i,
   output logic [island_pkg::NumTargets-1:0] tgt_req_o,
   output logic                              decerr_o
);

   import island_pkg::*;

   addr_t addr;
   logic  hit_host;
   logic  hit_cls;
   logic  miss;
   logic  decerr_q;

   assign addr = ini.payload.addr;

   // Rule match
   assign hit_host = (addr >= HostBase) && (addr < HostEnd);
   assign hit_cls  = (addr >= ClsBase) && (addr < ClsEnd);
   assign miss     = ~hit_host & ~hit_cls;

   always_comb begin
      tgt_req_o             = '0;
      tgt_req_o[TgtHost]    = ini.valid & hit_host;
      tgt_req_o[TgtCluster] = ini.valid & hit_cls;
   end

   // Misses are swallowed at once
   assign ini.ready = miss
                    | (hit_host & gnt_i[TgtHost])
                    | (hit_cls & gnt_i[TgtCluster]);

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         decerr_q <= 1'b0;
      end else begin
         decerr_q <= ini.valid & miss;
      end
   end

   assign decerr_o = decerr_q;

   ////////////////////////////////////////////////////////////////////////////
   // Assertions
   ////////////////////////////////////////////////////////////////////////////

   a_one_target : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      $onehot0(tgt_req_o)
   ) else $error("addr_decoder: request steered to more than one target");

   // Arbiters only grant what this decoder asked for
   a_gnt_requested : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      (gnt_i & ~tgt_req_o) == '0
   ) else $error("addr_decoder: grant from a target that was not requested");

endmodule

// ==== rtl/bus_req_if.sv ====
////////////////////////////////////////////////////////////////////////////
// Single-beat request channel with valid/ready handshake
////////////////////////////////////////////////////////////////////////////

interface bus_req_if;

   import island_pkg::*;

   logic         valid;
   logic         ready;
   req_payload_t payload;

   // Request source side
   modport initiator (
      output valid,
      output payload,
      input  ready
   );

   // Request sink side
   modport target (
      input  valid,
      input  payload,
      output ready
   );

endinterface

// ==== rtl/island_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Shared crossbar definitions: bus widths, port counts, target encoding,
// address map and the request payload carried on every channel
////////////////////////////////////////////////////////////////////////////

package island_pkg;

   localparam int unsigned AddrWidth     = 32;
   localparam int unsigned DataWidth     = 32;
   localparam int unsigned NumInitiators = 2;
   localparam int unsigned NumTargets    = 2;
   localparam int unsigned SrcWidth      = 1;

   typedef logic [AddrWidth-1:0] addr_t;
   typedef logic [DataWidth-1:0] data_t;
   typedef logic [SrcWidth-1:0]  src_t;

   typedef enum logic [0:0] {
      TgtHost    = 1'b0,
      TgtCluster = 1'b1
   } target_e;

   ////////////////////////////////////////////////////////////////////////////
   // Address map
   ////////////////////////////////////////////////////////////////////////////

   // End addresses are exclusive
   localparam addr_t HostBase = 32'h0001_0000;
   localparam addr_t HostEnd  = 32'hA000_0000;
   localparam addr_t ClsBase  = 32'hA100_0000;
   localparam addr_t ClsEnd   = 32'hB000_0000;

   ////////////////////////////////////////////////////////////////////////////
   // Request payload
   ////////////////////////////////////////////////////////////////////////////

   // 66 bits, src is the initiator index
   typedef struct packed {
      addr_t addr;
      data_t data;
      logic  write;
      src_t  src;
   } req_payload_t;

endpackage
